// ==== include/discrim_defs.svh ====
/*
  Sizing constants for the ADC sample discriminator.
  Include this before any package or module that sizes ports or buffers.
*/
`ifndef DISCRIM_DEFS_SVH
`define DISCRIM_DEFS_SVH

// receive channels, each with its own gate
`define DISCRIM_CHANNELS 2
// external digital trigger inputs
`define DISCRIM_DIG_INPUTS 2
// bits per ADC sample
`define DISCRIM_SAMPLE_WIDTH 16
// delay buffer depth, every programmed delay must be below it (power of two)
`define DISCRIM_MAX_DELAY 16
// sample index width
`define DISCRIM_TSTAMP_WIDTH 32
// APB byte address width
`define DISCRIM_APB_AW 8

`endif

// ==== hdl/discrim_sample_pkg.sv ====
/*
  Types carried along the sample path: samples, sample indices,
  delays and trigger source selects.
*/
`include "discrim_defs.svh"

package discrim_sample_pkg;

  // bits needed to name any analog channel or digital input
  localparam int SOURCE_W = $clog2(`DISCRIM_CHANNELS + `DISCRIM_DIG_INPUTS);

  // two's complement ADC sample
  typedef logic signed [`DISCRIM_SAMPLE_WIDTH-1:0] sample_t;

  // index of a valid sample since the last restart
  typedef logic [`DISCRIM_TSTAMP_WIDTH-1:0] tstamp_t;

  // delay counted in valid samples
  typedef logic [7:0] delay_t;

  // below DISCRIM_CHANNELS: analog trigger of that channel
  // otherwise: digital input (source - DISCRIM_CHANNELS)
  typedef logic [SOURCE_W-1:0] source_t;

endpackage

// ==== hdl/discrim_cfg_pkg.sv ====
/*
  Register map of the discriminator APB block. One 32-bit data word is
  decoded as a threshold pair or a delay triple, depending on the address.
*/
`include "discrim_defs.svh"

package discrim_cfg_pkg;

  import discrim_sample_pkg::*;

  typedef logic [`DISCRIM_APB_AW-1:0] apb_addr_t;

  // high threshold on top, low threshold below
  typedef struct packed {
    sample_t high;
    sample_t low;
  } threshold_word_t;

  // pad byte reads back as zero
  typedef struct packed {
    logic [7:0] pad;
    delay_t     dig;
    delay_t     stop;
    delay_t     start;
  } delay_word_t;

  // both views cover the same 32 bits
  typedef union packed {
    threshold_word_t thresh;
    delay_word_t     delay;
  } cfg_word_u;

  //////////////////////////////////////////////////
  // register offsets, one word per channel at THRESH0 and DELAY0
  //////////////////////////////////////////////////
  typedef enum logic [`DISCRIM_APB_AW-1:0] {
    THRESH0 = 'h00,
    DELAY0  = 'h10,
    SOURCE  = 'h20,
    BYPASS  = 'h24
  } reg_addr_e;

  localparam int REG_STRIDE = 4;

endpackage

// ==== hdl/apb_config_regs.sv ====
/*
  APB slave holding the discriminator configuration. Writes with an unmapped
  address or an out-of-range delay are refused with pslverr and change nothing.
*/
`timescale 1ns/1ps
`include "discrim_defs.svh"

module apb_config_regs
  import discrim_sample_pkg::*;
  import discrim_cfg_pkg::*;
(
  input  logic                              adc_clk,
  input  logic                              reset_i,
  input  logic                              psel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  apb_addr_t                         paddr_i,
  input  logic [31:0]                       pwdata_i,
  output logic [31:0]                       prdata_o,
  output logic                              pready_o,
  output logic                              pslverr_o,
  output sample_t [`DISCRIM_CHANNELS-1:0]   low_thresh_o,
  output sample_t [`DISCRIM_CHANNELS-1:0]   high_thresh_o,
  output delay_t  [`DISCRIM_CHANNELS-1:0]   start_delay_o,
  output delay_t  [`DISCRIM_CHANNELS-1:0]   stop_delay_o,
  output delay_t  [`DISCRIM_CHANNELS-1:0]   dig_delay_o,
  output source_t [`DISCRIM_CHANNELS-1:0]   source_o,
  output logic    [`DISCRIM_CHANNELS-1:0]   bypass_o
);

  localparam int CH = `DISCRIM_CHANNELS;

  threshold_word_t thresh_q [CH];
  delay_word_t     delay_q [CH];
  source_t [CH-1:0] source_q;
  logic    [CH-1:0] bypass_q;

  cfg_word_u    wr_word;
  logic [CH-1:0] thr_hit;
  logic [CH-1:0] dly_hit;
  logic          src_hit;
  logic          byp_hit;
  logic          mapped;
  logic          delay_bad;
  logic          access_err;
  logic          access;

  assign wr_word = pwdata_i;
  assign access  = psel_i && penable_i;

  //////////////////////////////////////////////////
  // address decode and read mux
  //////////////////////////////////////////////////
  always_comb begin
    prdata_o = '0;
    for (int c = 0; c < CH; c++) begin
      thr_hit[c] = (paddr_i == apb_addr_t'(THRESH0 + REG_STRIDE * c));
      dly_hit[c] = (paddr_i == apb_addr_t'(DELAY0 + REG_STRIDE * c));
      if (thr_hit[c]) prdata_o = thresh_q[c];
      if (dly_hit[c]) prdata_o = delay_q[c];
    end
    src_hit = (paddr_i == SOURCE);
    byp_hit = (paddr_i == BYPASS);
    if (src_hit) prdata_o = 32'(source_q);
    if (byp_hit) prdata_o = 32'(bypass_q);
  end

  assign mapped    = (|thr_hit) || (|dly_hit) || src_hit || byp_hit;
  // any delay field at or above the buffer depth is refused
  assign delay_bad = (wr_word.delay.start >= `DISCRIM_MAX_DELAY) ||
                     (wr_word.delay.stop  >= `DISCRIM_MAX_DELAY) ||
                     (wr_word.delay.dig   >= `DISCRIM_MAX_DELAY);
  assign access_err = !mapped || (pwrite_i && (|dly_hit) && delay_bad);

  assign pready_o  = 1'b1;
  assign pslverr_o = access && access_err;

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      for (int c = 0; c < CH; c++) begin
        thresh_q[c] <= '0;
        delay_q[c]  <= '0;
      end
      source_q <= '0;
      bypass_q <= '0;
    end else if (access && pwrite_i && !access_err) begin
      for (int c = 0; c < CH; c++) begin
        if (thr_hit[c]) thresh_q[c] <= wr_word.thresh;
        if (dly_hit[c]) delay_q[c] <= '{pad: '0, dig: wr_word.delay.dig,
                                        stop: wr_word.delay.stop,
                                        start: wr_word.delay.start};
      end
      if (src_hit) source_q <= pwdata_i[CH*SOURCE_W-1:0];
      if (byp_hit) bypass_q <= pwdata_i[CH-1:0];
    end
  end

  always_comb begin
    for (int c = 0; c < CH; c++) begin
      low_thresh_o[c]  = thresh_q[c].low;
      high_thresh_o[c] = thresh_q[c].high;
      start_delay_o[c] = delay_q[c].start;
      stop_delay_o[c]  = delay_q[c].stop;
      dig_delay_o[c]   = delay_q[c].dig;
    end
  end

  assign source_o = source_q;
  assign bypass_o = bypass_q;

  // access phase only ever follows a selected setup phase
  a_apb_phase : assert property (@(posedge adc_clk) disable iff (reset_i)
    penable_i |-> psel_i && $past(psel_i));

endmodule

// ==== hdl/hysteresis_comparator.sv ====
/*
  Analog trigger of one receive channel. The state sets above the high
  threshold, clears below the low one and otherwise holds.
*/
`timescale 1ns/1ps

module hysteresis_comparator
  import discrim_sample_pkg::*;
(
  input  logic    adc_clk,
  input  logic    reset_i,
  input  logic    restart_i,
  input  sample_t sample_i,
  input  logic    valid_i,
  input  sample_t low_i,
  input  sample_t high_i,
  output logic    state_o
);

  // signed compare, both thresholds are sample_t
  always_ff @(posedge adc_clk) begin
    if (reset_i || restart_i) begin
      state_o <= 1'b0;
    end else if (valid_i) begin
      if (sample_i > high_i) begin
        state_o <= 1'b1;
      end else if (sample_i < low_i) begin
        state_o <= 1'b0;
      end
    end
  end

  // state only moves on a valid sample or a restart
  a_state_hold : assert property (@(posedge adc_clk) disable iff (reset_i)
    !valid_i && !restart_i |=> $stable(state_o));

endmodule

// ==== hdl/sample_delay_line.sv ====
/*
  Circular buffer that returns the word written delay_i valid samples ago.
  A zero delay passes din_i straight through. DEPTH must be a power of two.
*/
`timescale 1ns/1ps

module sample_delay_line
  import discrim_sample_pkg::*;
#(
  parameter int WIDTH = 16,
  parameter int DEPTH = 16
) (
  input  logic             adc_clk,
  input  logic             reset_i,
  input  logic             restart_i,
  input  logic [WIDTH-1:0] din_i,
  input  logic             valid_i,
  input  delay_t           delay_i,
  output logic [WIDTH-1:0] dout_o,
  output logic             dout_ok_o
);

  localparam int AW = $clog2(DEPTH);

  logic [WIDTH-1:0] ring [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  // writes since restart, saturating once the whole ring is history
  logic [AW-1:0]    fill_cnt;

  // pointer wraps by truncation
  assign rd_ptr    = wr_ptr - delay_i[AW-1:0];
  assign dout_o    = (delay_i == '0) ? din_i : ring[rd_ptr];
  assign dout_ok_o = (delay_t'(fill_cnt) >= delay_i);

  always_ff @(posedge adc_clk) begin
    if (valid_i) ring[wr_ptr] <= din_i;
  end

  always_ff @(posedge adc_clk) begin
    if (reset_i || restart_i) begin
      wr_ptr   <= '0;
      fill_cnt <= '0;
    end else if (valid_i) begin
      wr_ptr <= wr_ptr + 1'b1;
      if (fill_cnt != AW'(DEPTH - 1)) fill_cnt <= fill_cnt + 1'b1;
    end
  end

  // the register block must keep delays inside the ring
  a_delay_range : assert property (@(posedge adc_clk) disable iff (reset_i)
    valid_i |-> int'(delay_i) < DEPTH);

endmodule

// ==== hdl/trigger_router.sv ====
/*
  Picks each channel's trigger: an analog comparator state, or a digital
  input bit delayed by the channel's digital delay. Output is registered.
*/
`timescale 1ns/1ps
`include "discrim_defs.svh"

module trigger_router
  import discrim_sample_pkg::*;
(
  input  logic                              adc_clk,
  input  logic                              reset_i,
  input  logic                              restart_i,
  input  logic                              valid_i,
  input  logic    [`DISCRIM_CHANNELS-1:0]   analog_i,
  input  logic    [`DISCRIM_DIG_INPUTS-1:0] dig_trigger_i,
  input  delay_t  [`DISCRIM_CHANNELS-1:0]   dig_delay_i,
  input  source_t [`DISCRIM_CHANNELS-1:0]   source_i,
  output logic    [`DISCRIM_CHANNELS-1:0]   trigger_o,
  output logic                              trigger_valid_o
);

  localparam int CH  = `DISCRIM_CHANNELS;
  localparam int DIG = `DISCRIM_DIG_INPUTS;

  logic [CH-1:0] route;

  for (genvar c = 0; c < CH; c++) begin : g_chan
    logic dig_sel;
    logic dig_dly;
    logic dig_ok;
    logic route_bit;

    // delay only the digital bit this channel listens to
    sample_delay_line #(
      .WIDTH(1),
      .DEPTH(`DISCRIM_MAX_DELAY)
    ) u_dig_delay (
      .adc_clk  (adc_clk),
      .reset_i  (reset_i),
      .restart_i(restart_i),
      .din_i    (dig_sel),
      .valid_i  (valid_i),
      .delay_i  (dig_delay_i[c]),
      .dout_o   (dig_dly),
      .dout_ok_o(dig_ok)
    );

    always_comb begin
      dig_sel   = 1'b0;
      // before the delay has filled the trigger reads as 0
      route_bit = dig_dly & dig_ok;
      for (int a = 0; a < CH; a++) begin
        if (source_i[c] == source_t'(a)) route_bit = analog_i[a];
      end
      for (int d = 0; d < DIG; d++) begin
        if (source_i[c] == source_t'(CH + d)) dig_sel = dig_trigger_i[d];
      end
    end

    assign route[c] = route_bit;
  end

  always_ff @(posedge adc_clk) begin
    if (reset_i || restart_i) begin
      trigger_o       <= '0;
      trigger_valid_o <= 1'b0;
    end else begin
      trigger_valid_o <= valid_i;
      if (valid_i) trigger_o <= route;
    end
  end

endmodule

// ==== hdl/sample_gate.sv ====
/*
  Output gate of one channel. Offers the sample start_delay samples back,
  holds the gate open start+stop samples after the trigger, and marks the
  first sample of each window with its sample index.
*/
`timescale 1ns/1ps
`include "discrim_defs.svh"

module sample_gate
  import discrim_sample_pkg::*;
(
  input  logic    adc_clk,
  input  logic    reset_i,
  input  logic    restart_i,
  input  sample_t sample_i,
  input  logic    valid_i,
  input  logic    trigger_i,
  input  delay_t  start_delay_i,
  input  delay_t  stop_delay_i,
  input  logic    bypass_i,
  output sample_t data_o,
  output logic    data_valid_o,
  output tstamp_t tstamp_o,
  output logic    tstamp_valid_o
);

  sample_t pre_sample;
  logic    pre_ok;
  tstamp_t sample_idx;
  delay_t  hold_cnt;
  logic    prev_emit;
  logic    gate_open;
  logic    emit;
  logic    window_start;

  // pre-trigger history
  sample_delay_line #(
    .WIDTH(`DISCRIM_SAMPLE_WIDTH),
    .DEPTH(`DISCRIM_MAX_DELAY)
  ) u_pre_delay (
    .adc_clk  (adc_clk),
    .reset_i  (reset_i),
    .restart_i(restart_i),
    .din_i    (sample_i),
    .valid_i  (valid_i),
    .delay_i  (start_delay_i),
    .dout_o   (pre_sample),
    .dout_ok_o(pre_ok)
  );

  // open now, or triggered within the last start+stop samples
  assign gate_open    = trigger_i || (hold_cnt != '0);
  // no emission until the offered index is at least 0
  assign emit         = gate_open && pre_ok;
  assign window_start = emit && !prev_emit;

  //////////////////////////////////////////////////
  // control state
  //////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (reset_i || restart_i) begin
      sample_idx     <= '0;
      hold_cnt       <= '0;
      prev_emit      <= 1'b0;
      data_valid_o   <= 1'b0;
      tstamp_valid_o <= 1'b0;
    end else begin
      data_valid_o   <= valid_i && (bypass_i || emit);
      tstamp_valid_o <= valid_i && !bypass_i && window_start;
      if (valid_i) begin
        sample_idx <= sample_idx + 1'b1;
        prev_emit  <= emit;
        if (trigger_i) begin
          hold_cnt <= start_delay_i + stop_delay_i;
        end else if (hold_cnt != '0) begin
          hold_cnt <= hold_cnt - 1'b1;
        end
      end
    end
  end

  // payload, the index stamped is that of the offered sample
  always_ff @(posedge adc_clk) begin
    if (valid_i) begin
      data_o   <= bypass_i ? sample_i : pre_sample;
      tstamp_o <= sample_idx - tstamp_t'(start_delay_i);
    end
  end

  a_tstamp_with_data : assert property (@(posedge adc_clk) disable iff (reset_i)
    tstamp_valid_o |-> data_valid_o);

endmodule

// ==== hdl/discrim_top.sv ====
/*
  Sample discriminator top level. APB configuration, per-channel analog
  comparators, the trigger router and one output gate per channel.
*/
`timescale 1ns/1ps
`include "discrim_defs.svh"

module discrim_top
  import discrim_sample_pkg::*;
  import discrim_cfg_pkg::*;
(
  input  logic                              adc_clk,
  input  logic                              reset_i,
  input  logic                              psel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  apb_addr_t                         paddr_i,
  input  logic [31:0]                       pwdata_i,
  output logic [31:0]                       prdata_o,
  output logic                              pready_o,
  output logic                              pslverr_o,
  input  sample_t [`DISCRIM_CHANNELS-1:0]   data_i,
  input  logic                              data_valid_i,
  input  logic    [`DISCRIM_DIG_INPUTS-1:0] dig_trigger_i,
  input  logic                              adc_reset_state_i,
  output sample_t [`DISCRIM_CHANNELS-1:0]   data_o,
  output logic    [`DISCRIM_CHANNELS-1:0]   data_valid_o,
  output tstamp_t [`DISCRIM_CHANNELS-1:0]   tstamp_o,
  output logic    [`DISCRIM_CHANNELS-1:0]   tstamp_valid_o
);

  localparam int CH = `DISCRIM_CHANNELS;

  sample_t [CH-1:0] low_thresh;
  sample_t [CH-1:0] high_thresh;
  delay_t  [CH-1:0] start_delay;
  delay_t  [CH-1:0] stop_delay;
  delay_t  [CH-1:0] dig_delay;
  source_t [CH-1:0] source;
  logic    [CH-1:0] bypass;
  logic    [CH-1:0] analog_state;
  logic    [CH-1:0] trigger;
  logic             trigger_valid;
  logic             in_valid;
  logic             valid_d1;
  logic [`DISCRIM_DIG_INPUTS-1:0] dig_d1;
  sample_t [CH-1:0] sample_d1;
  sample_t [CH-1:0] sample_d2;

  // samples arriving during a restart are dropped
  assign in_valid = data_valid_i && !adc_reset_state_i;

  apb_config_regs u_regs (
    .adc_clk, .reset_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .low_thresh_o(low_thresh), .high_thresh_o(high_thresh),
    .start_delay_o(start_delay), .stop_delay_o(stop_delay), .dig_delay_o(dig_delay),
    .source_o(source), .bypass_o(bypass)
  );

  // stage 1 sits beside the comparators, stage 2 beside the router
  always_ff @(posedge adc_clk) begin
    if (reset_i || adc_reset_state_i) valid_d1 <= 1'b0;
    else valid_d1 <= in_valid;
  end

  always_ff @(posedge adc_clk) begin
    dig_d1    <= dig_trigger_i;
    sample_d1 <= data_i;
    sample_d2 <= sample_d1;
  end

  for (genvar c = 0; c < CH; c++) begin : g_cmp
    hysteresis_comparator u_cmp (
      .adc_clk, .reset_i, .restart_i(adc_reset_state_i),
      .sample_i(data_i[c]), .valid_i(in_valid),
      .low_i(low_thresh[c]), .high_i(high_thresh[c]), .state_o(analog_state[c])
    );
  end

  trigger_router u_router (
    .adc_clk, .reset_i, .restart_i(adc_reset_state_i), .valid_i(valid_d1),
    .analog_i(analog_state), .dig_trigger_i(dig_d1), .dig_delay_i(dig_delay),
    .source_i(source), .trigger_o(trigger), .trigger_valid_o(trigger_valid)
  );

  for (genvar c = 0; c < CH; c++) begin : g_gate
    sample_gate u_gate (
      .adc_clk, .reset_i, .restart_i(adc_reset_state_i),
      .sample_i(sample_d2[c]), .valid_i(trigger_valid), .trigger_i(trigger[c]),
      .start_delay_i(start_delay[c]), .stop_delay_i(stop_delay[c]), .bypass_i(bypass[c]),
      .data_o(data_o[c]), .data_valid_o(data_valid_o[c]),
      .tstamp_o(tstamp_o[c]), .tstamp_valid_o(tstamp_valid_o[c])
    );
  end

endmodule

// ==== verification/discrim_checker.sv ====
/*
  Watches the discriminator ports. Keeps a register model, records each
  segment of samples between restarts and compares outputs with a reference.
*/
`timescale 1ns/1ps
`include "discrim_defs.svh"

module discrim_checker
  import discrim_sample_pkg::*;
  import discrim_cfg_pkg::*;
(
  input  logic                                  adc_clk,
  input  logic                                  reset_i,
  input  logic                                  psel_i,
  input  logic                                  penable_i,
  input  logic                                  pwrite_i,
  input  apb_addr_t                             paddr_i,
  input  logic [31:0]                           pwdata_i,
  input  logic [31:0]                           prdata_i,
  input  logic                                  pready_i,
  input  logic                                  pslverr_i,
  input  sample_t [`DISCRIM_CHANNELS-1:0]       data_i,
  input  logic                                  data_valid_i,
  input  logic    [`DISCRIM_DIG_INPUTS-1:0]     dig_trigger_i,
  input  logic                                  adc_reset_state_i,
  input  sample_t [`DISCRIM_CHANNELS-1:0]       out_data_i,
  input  logic    [`DISCRIM_CHANNELS-1:0]       out_valid_i,
  input  tstamp_t [`DISCRIM_CHANNELS-1:0]       out_tstamp_i,
  input  logic    [`DISCRIM_CHANNELS-1:0]       out_ts_valid_i,
  output int                                    value_errors_o,
  output int                                    other_errors_o
);

  localparam int CH   = `DISCRIM_CHANNELS;
  localparam int MAXN = 512;

  // register model
  threshold_word_t thr_q [CH];
  delay_word_t     dly_q [CH];
  logic [31:0]     src_q;
  logic [31:0]     byp_q;

  // current segment, ts of -1 means no timestamp
  sample_t seg_x [CH][MAXN];
  logic [`DISCRIM_DIG_INPUTS-1:0] seg_dig [MAXN];
  int      seg_n;
  sample_t got_x [CH][MAXN];
  longint  got_ts [CH][MAXN];
  time     got_t [CH][MAXN];
  int      got_n [CH];
  sample_t exp_x [CH][MAXN];
  longint  exp_ts [CH][MAXN];
  int      exp_n [CH];
  logic [2:0] vhist;

  function automatic logic [31:0] read_model(input apb_addr_t a);
    read_model = '0;
    for (int c = 0; c < CH; c++) begin
      if (a == apb_addr_t'(THRESH0 + REG_STRIDE * c)) read_model = thr_q[c];
      if (a == apb_addr_t'(DELAY0 + REG_STRIDE * c)) read_model = dly_q[c];
    end
    if (a == SOURCE) read_model = src_q;
    if (a == BYPASS) read_model = byp_q;
  endfunction

  function automatic bit is_delay_addr(input apb_addr_t a);
    is_delay_addr = 1'b0;
    for (int c = 0; c < CH; c++) begin
      if (a == apb_addr_t'(DELAY0 + REG_STRIDE * c)) is_delay_addr = 1'b1;
    end
  endfunction

  function automatic bit is_mapped(input apb_addr_t a);
    is_mapped = is_delay_addr(a) || a == SOURCE || a == BYPASS;
    for (int c = 0; c < CH; c++) begin
      if (a == apb_addr_t'(THRESH0 + REG_STRIDE * c)) is_mapped = 1'b1;
    end
  endfunction

  //////////////////////////////////////////////////
  // reference model of one channel over a segment
  //////////////////////////////////////////////////
  function automatic void compute_expected(input int c);
    logic [CH-1:0] st;
    bit trig [MAXN];
    int span;
    int src;
    int idx;
    int d;
    bit open;
    bit prev;
    st       = '0;
    prev     = 1'b0;
    exp_n[c] = 0;
    span = int'(dly_q[c].start) + int'(dly_q[c].stop);
    src  = int'(src_q[c*SOURCE_W +: SOURCE_W]);
    for (int n = 0; n < seg_n; n++) begin
      for (int a = 0; a < CH; a++) begin
        if (seg_x[a][n] > $signed(thr_q[a].high)) st[a] = 1'b1;
        else if (seg_x[a][n] < $signed(thr_q[a].low)) st[a] = 1'b0;
      end
      if (src < CH) begin
        trig[n] = st[src];
      end else begin
        d = n - int'(dly_q[c].dig);
        trig[n] = (d >= 0) ? seg_dig[d][src-CH] : 1'b0;
      end
      if (byp_q[c]) begin
        exp_x[c][exp_n[c]]  = seg_x[c][n];
        exp_ts[c][exp_n[c]] = -1;
        exp_n[c]++;
      end else begin
        open = trig[n];
        for (int k = 1; k <= span; k++) begin
          if (n - k >= 0 && trig[n-k]) open = 1'b1;
        end
        idx = n - int'(dly_q[c].start);
        if (open && idx >= 0) begin
          exp_x[c][exp_n[c]]  = seg_x[c][idx];
          exp_ts[c][exp_n[c]] = prev ? -1 : idx;
          exp_n[c]++;
          prev = 1'b1;
        end else begin
          prev = 1'b0;
        end
      end
    end
  endfunction

  task automatic compare_segment();
    int m;
    for (int c = 0; c < CH; c++) begin
      compute_expected(c);
      if (exp_n[c] != got_n[c]) begin
        other_errors_o++;
        $display("channel %0d emitted %0d samples in a segment, the model expects %0d",
                 c, got_n[c], exp_n[c]);
      end
      m = (exp_n[c] < got_n[c]) ? exp_n[c] : got_n[c];
      for (int i = 0; i < m; i++) begin
        if (got_x[c][i] !== exp_x[c][i]) begin
          value_errors_o++;
          $display("Error at %0t: data_o[%0d] got %0d expected %0d",
                   got_t[c][i], c, got_x[c][i], exp_x[c][i]);
        end
        // -1 stands for no tstamp_valid_o
        if (got_ts[c][i] != exp_ts[c][i]) begin
          value_errors_o++;
          $display("Error at %0t: tstamp_o[%0d] got %0d expected %0d",
                   got_t[c][i], c, got_ts[c][i], exp_ts[c][i]);
        end
      end
      got_n[c] = 0;
    end
    seg_n = 0;
  endtask

  always @(posedge adc_clk) begin : watch
    cfg_word_u w;
    bit exp_err;
    bit bad_dly;
    if (reset_i) begin
      for (int c = 0; c < CH; c++) begin
        thr_q[c] = '0;
        dly_q[c] = '0;
        got_n[c] = 0;
      end
      src_q = '0;
      byp_q = '0;
      seg_n = 0;
      vhist = '0;
    end else begin
      // outputs first, so a segment closes with everything it produced
      for (int c = 0; c < CH; c++) begin
        if (out_valid_i[c]) begin
          if (byp_q[c] && !vhist[2]) begin
            other_errors_o++;
            $display("bypassed channel %0d output at %0t was not 3 cycles after an input",
                     c, $time);
          end
          if (got_n[c] < MAXN) begin
            got_x[c][got_n[c]]  = out_data_i[c];
            got_ts[c][got_n[c]] = out_ts_valid_i[c] ? longint'(out_tstamp_i[c]) : -1;
            got_t[c][got_n[c]]  = $time;
            got_n[c]++;
          end
        end else if (out_ts_valid_i[c]) begin
          other_errors_o++;
          $display("channel %0d gave a timestamp without data at %0t", c, $time);
        end
      end
      vhist = {vhist[1:0], data_valid_i && !adc_reset_state_i};

      if (adc_reset_state_i) begin
        if (seg_n > 0 || got_n[0] > 0 || got_n[CH-1] > 0) compare_segment();
      end else if (data_valid_i && seg_n < MAXN) begin
        for (int c = 0; c < CH; c++) seg_x[c][seg_n] = data_i[c];
        seg_dig[seg_n] = dig_trigger_i;
        seg_n++;
      end

      // the slave never inserts wait states
      if (pready_i !== 1'b1) begin
        value_errors_o++;
        $display("Error at %0t: pready_o got %b expected 1", $time, pready_i);
      end

      if (psel_i && penable_i) begin
        w       = pwdata_i;
        bad_dly = w.delay.start >= `DISCRIM_MAX_DELAY || w.delay.stop >= `DISCRIM_MAX_DELAY ||
                  w.delay.dig >= `DISCRIM_MAX_DELAY;
        exp_err = !is_mapped(paddr_i) || (pwrite_i && is_delay_addr(paddr_i) && bad_dly);
        if (pslverr_i !== exp_err) begin
          value_errors_o++;
          $display("Error at %0t: pslverr_o got %b expected %b", $time, pslverr_i, exp_err);
        end
        if (!pwrite_i && prdata_i !== read_model(paddr_i)) begin
          value_errors_o++;
          $display("Error at %0t: prdata_o got %h expected %h",
                   $time, prdata_i, read_model(paddr_i));
        end
        if (pwrite_i && !exp_err) begin
          for (int c = 0; c < CH; c++) begin
            if (paddr_i == apb_addr_t'(THRESH0 + REG_STRIDE * c)) thr_q[c] = w.thresh;
            if (paddr_i == apb_addr_t'(DELAY0 + REG_STRIDE * c)) begin
              dly_q[c]     = w.delay;
              dly_q[c].pad = '0;
            end
          end
          if (paddr_i == SOURCE) src_q = pwdata_i & ((32'd1 << (CH * SOURCE_W)) - 1);
          if (paddr_i == BYPASS) byp_q = pwdata_i & ((32'd1 << CH) - 1);
        end
      end else if (pslverr_i !== 1'b0) begin
        value_errors_o++;
        $display("Error at %0t: pslverr_o got %b expected 0", $time, pslverr_i);
      end
    end
  end

endmodule

// ==== verification/discrim_tb.sv ====
/*
  Testbench for the sample discriminator. Drives APB configuration, random
  ADC samples and digital triggers; discrim_checker does all comparing.
*/
`timescale 1ns/1ps
`include "discrim_defs.svh"

module discrim_tb
  import discrim_sample_pkg::*;
  import discrim_cfg_pkg::*;
;
  localparam int CH       = `DISCRIM_CHANNELS;
  localparam int SAMPLES  = 200;
  // six cases plus the second segment of the restart case
  localparam int SEGMENTS = 7;
  localparam longint LIMIT_NS = SEGMENTS * SAMPLES * 4 * 8 + 20000;

  logic adc_clk;
  logic reset_i;
  logic psel;
  logic penable;
  logic pwrite;
  apb_addr_t paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;
  sample_t [CH-1:0] adc_data;
  logic adc_valid;
  logic [`DISCRIM_DIG_INPUTS-1:0] dig_trig;
  logic adc_restart;
  sample_t [CH-1:0] out_data;
  logic [CH-1:0] out_valid;
  tstamp_t [CH-1:0] out_tstamp;
  logic [CH-1:0] out_ts_valid;
  int value_errors;
  int other_errors;

  discrim_top uut (
    .adc_clk(adc_clk), .reset_i(reset_i),
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
    .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
    .data_i(adc_data), .data_valid_i(adc_valid), .dig_trigger_i(dig_trig),
    .adc_reset_state_i(adc_restart),
    .data_o(out_data), .data_valid_o(out_valid),
    .tstamp_o(out_tstamp), .tstamp_valid_o(out_ts_valid)
  );

  discrim_checker u_checker (
    .adc_clk(adc_clk), .reset_i(reset_i),
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
    .pwdata_i(pwdata), .prdata_i(prdata), .pready_i(pready), .pslverr_i(pslverr),
    .data_i(adc_data), .data_valid_i(adc_valid), .dig_trigger_i(dig_trig),
    .adc_reset_state_i(adc_restart),
    .out_data_i(out_data), .out_valid_i(out_valid),
    .out_tstamp_i(out_tstamp), .out_ts_valid_i(out_ts_valid),
    .value_errors_o(value_errors), .other_errors_o(other_errors)
  );

  initial begin
    adc_clk = 1'b0;
    forever #4 adc_clk = ~adc_clk;
  end

  initial begin
    #(LIMIT_NS);
    $display("watchdog expired, the run did not finish in time");
    $display("SOME TESTS FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // APB master
  //////////////////////////////////////////////////
  task automatic apb_access(input bit write, input apb_addr_t addr, input logic [31:0] wdata);
    @(posedge adc_clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge adc_clk);
    penable <= 1'b1;
    @(posedge adc_clk);
    while (!pready) @(posedge adc_clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic read_all_regs();
    for (int c = 0; c < CH; c++) begin
      apb_access(1'b0, apb_addr_t'(THRESH0 + REG_STRIDE * c), '0);
      apb_access(1'b0, apb_addr_t'(DELAY0 + REG_STRIDE * c), '0);
    end
    apb_access(1'b0, SOURCE, '0);
    apb_access(1'b0, BYPASS, '0);
  endtask

  // zero_dly: all delays 0, own_src: each channel on its own analog trigger
  task automatic configure(input bit zero_dly, input bit own_src, input logic [31:0] byp);
    sample_t lo;
    sample_t hi;
    sample_t tmp;
    logic [31:0] src;
    logic [7:0] dly [3];
    src = '0;
    for (int c = 0; c < CH; c++) begin
      lo = sample_t'($urandom);
      hi = sample_t'($urandom);
      if (lo > hi) begin
        tmp = lo;
        lo  = hi;
        hi  = tmp;
      end
      apb_access(1'b1, apb_addr_t'(THRESH0 + REG_STRIDE * c), {hi, lo});
      for (int f = 0; f < 3; f++) dly[f] = zero_dly ? 8'd0 : 8'($urandom_range(0, 15));
      apb_access(1'b1, apb_addr_t'(DELAY0 + REG_STRIDE * c), {8'h00, dly[2], dly[1], dly[0]});
      src[c*SOURCE_W +: SOURCE_W] = own_src ? source_t'(c) : source_t'($urandom);
    end
    apb_access(1'b1, SOURCE, src);
    apb_access(1'b1, BYPASS, byp);
    read_all_regs();
  endtask

  //////////////////////////////////////////////////
  // sample path
  //////////////////////////////////////////////////
  // lets the pipeline drain, then holds the restart
  task automatic begin_restart();
    adc_valid <= 1'b0;
    repeat (6) @(posedge adc_clk);
    adc_restart <= 1'b1;
    @(posedge adc_clk);
  endtask

  task automatic end_restart();
    @(posedge adc_clk);
    adc_restart <= 1'b0;
  endtask

  task automatic send_samples(input int count);
    int sent;
    int density;
    bit v;
    sent    = 0;
    density = $urandom_range(1, 4);
    while (sent < count) begin
      @(posedge adc_clk);
      v = ($urandom_range(0, density - 1) == 0);
      adc_valid <= v;
      for (int c = 0; c < CH; c++) adc_data[c] <= sample_t'($urandom);
      dig_trig <= `DISCRIM_DIG_INPUTS'($urandom);
      if (v) sent++;
    end
    @(posedge adc_clk);
    adc_valid <= 1'b0;
  endtask

  initial begin
    void'($urandom(9));
    reset_i     = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    adc_data    = '0;
    adc_valid   = 1'b0;
    dig_trig    = '0;
    adc_restart = 1'b0;
    repeat (8) @(posedge adc_clk);
    reset_i <= 1'b0;

    // register access, refused delays and unmapped addresses
    begin_restart();
    configure(1'b0, 1'b0, $urandom);
    apb_access(1'b1, DELAY0, {8'h00, 8'd3, 8'($urandom_range(16, 255)), 8'd2});
    apb_access(1'b1, DELAY0, {8'h00, 8'($urandom_range(16, 255)), 8'd1, 8'd1});
    apb_access(1'b1, apb_addr_t'(DELAY0 + REG_STRIDE), {8'h00, 8'd0, 8'd0, 8'd16});
    apb_access(1'b1, 8'h08, $urandom);
    apb_access(1'b0, 8'h30, '0);
    read_all_regs();
    apb_access(1'b1, BYPASS, '0);
    end_restart();
    send_samples(SAMPLES);

    // analog hysteresis, no delays
    begin_restart();
    configure(1'b1, 1'b1, '0);
    end_restart();
    send_samples(SAMPLES);

    // pre and post trigger windows
    begin_restart();
    configure(1'b0, 1'b1, '0);
    end_restart();
    send_samples(SAMPLES);

    // digital and cross-channel sources
    begin_restart();
    configure(1'b0, 1'b0, '0);
    end_restart();
    send_samples(SAMPLES);

    // bypassed channels
    begin_restart();
    configure(1'b0, 1'b0, $urandom_range(1, (1 << CH) - 1));
    end_restart();
    send_samples(SAMPLES);

    // restart halfway through a case
    begin_restart();
    configure(1'b0, 1'b0, '0);
    end_restart();
    send_samples(SAMPLES / 2);
    begin_restart();
    end_restart();
    send_samples(SAMPLES);

    // final restart closes the last segment in the checker
    begin_restart();
    repeat (4) @(posedge adc_clk);
    end_restart();
    repeat (2) @(posedge adc_clk);

    $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+include
hdl/discrim_sample_pkg.sv
hdl/discrim_cfg_pkg.sv
hdl/apb_config_regs.sv
hdl/hysteresis_comparator.sv
hdl/sample_delay_line.sv
hdl/trigger_router.sv
hdl/sample_gate.sv
hdl/discrim_top.sv
verification/discrim_checker.sv
verification/discrim_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the discriminator testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module discrim_tb \
  -f project.f -o discrim_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/discrim_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
  exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0
